// ==== vlog.f ====
+incdir+bench
common/cpu_pkg.sv
common/fwd_if.sv
decode/reg_file.sv
decode/decode_stage.sv
source/fetch_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
bench/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert -j 0 --top-module tb_cpu -f vlog.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim || exit 1

// ==== bench/tb_tests.svh ====
task automatic test_alu_imm();
    start_program();
    op_lu12i(5'd1, 20'h12345);            // 0x12345000
    op_addi(5'd2, 5'd0, 12'h678);
    op_addi(5'd3, 5'd0, 12'hff0);         // Negative immediate
    op_r3(OP_ADD_W, 5'd4, 5'd1, 5'd2);
    op_r3(OP_SUB_W, 5'd5, 5'd2, 5'd3);
    op_r3(OP_AND, 5'd6, 5'd1, 5'd3);
    op_r3(OP_OR, 5'd7, 5'd1, 5'd2);
    op_r3(OP_XOR, 5'd8, 5'd1, 5'd3);
    op_r3(OP_SLT, 5'd9, 5'd3, 5'd2);      // Signed, so -16 is less
    op_r3(OP_SLT, 5'd10, 5'd2, 5'd3);
    run_program("alu_imm");
endtask

task automatic test_forwarding();
    start_program();
    op_addi(5'd1, 5'd0, 12'h011);
    op_addi(5'd2, 5'd1, 12'h022);         // Distance one
    op_addi(5'd3, 5'd0, 12'h100);
    op_r3(OP_ADD_W, 5'd4, 5'd1, 5'd2);    // Distances three and two
    op_r3(OP_SUB_W, 5'd5, 5'd4, 5'd3);    // Distances one and two
    op_r3(OP_XOR, 5'd6, 5'd5, 5'd4);
    op_r3(OP_OR, 5'd7, 5'd4, 5'd6);       // r4 from three back
    op_addi(5'd7, 5'd7, 12'h800);
    op_addi(5'd7, 5'd7, 12'h001);
    op_r3(OP_ADD_W, 5'd8, 5'd7, 5'd7);    // Youngest r7 must win
    run_program("forwarding");
endtask

task automatic test_load_store();
    start_program();
    op_lu12i(5'd1, 20'h1c010);            // Data base address
    op_addi(5'd2, 5'd0, 12'h5a5);
    op_lu12i(5'd3, 20'hdead0);
    op_addi(5'd3, 5'd3, 12'h0ef);
    op_st(5'd2, 5'd1, 12'h000);
    op_st(5'd3, 5'd1, 12'h004);
    op_st(5'd1, 5'd1, 12'h008);
    op_ld(5'd4, 5'd1, 12'h004);
    op_r3(OP_ADD_W, 5'd5, 5'd4, 5'd2);    // Load-use
    op_ld(5'd6, 5'd1, 12'h000);
    op_ld(5'd7, 5'd1, 12'h008);
    op_st(5'd6, 5'd7, 12'h00c);           // Loaded base and loaded data
    op_ld(5'd8, 5'd1, 12'h00c);
    op_r3(OP_SUB_W, 5'd9, 5'd8, 5'd6);
    for (int i = 0; i < 4; i++) begin
        op_addi(5'd2, 5'd2, 12'h111);
        op_st(5'd2, 5'd1, 12'(16 + 4 * i));
        op_ld(5'd10, 5'd1, 12'(16 + 4 * i));
        op_r3(OP_XOR, 5'd11, 5'd10, 5'd3);
    end
    run_program("load_store");
endtask

task automatic test_branches();
    start_program();
    op_addi(5'd1, 5'd0, 12'h007);
    op_addi(5'd2, 5'd0, 12'h007);
    op_addi(5'd3, 5'd0, 12'h009);
    op_branch(OP_BEQ, 5'd1, 5'd2);        // Taken
    op_branch(OP_BNE, 5'd1, 5'd3);        // Taken
    op_branch(OP_BEQ, 5'd1, 5'd3);        // Falls through
    op_branch(OP_BNE, 5'd1, 5'd2);        // Falls through
    op_addi(5'd4, 5'd3, 12'hffe);
    op_branch(OP_BEQ, 5'd4, 5'd1);        // Compare on a value from EX
    op_lu12i(5'd5, 20'h1c010);
    op_st(5'd4, 5'd5, 12'h040);
    op_ld(5'd6, 5'd5, 12'h040);
    op_branch(OP_BNE, 5'd6, 5'd3);        // Load-use before a taken branch
    op_r3(OP_ADD_W, 5'd7, 5'd6, 5'd4);
    run_program("branches");
endtask

task automatic test_r0();
    start_program();
    op_addi(5'd0, 5'd0, 12'h123);
    op_lu12i(5'd0, 20'hfffff);
    op_r3(OP_ADD_W, 5'd1, 5'd0, 5'd0);    // Right after a write to r0
    op_addi(5'd2, 5'd0, 12'h055);
    op_r3(OP_OR, 5'd0, 5'd2, 5'd2);
    op_r3(OP_OR, 5'd3, 5'd0, 5'd2);
    op_lu12i(5'd4, 20'h1c010);
    op_st(5'd2, 5'd4, 12'h080);
    op_ld(5'd0, 5'd4, 12'h080);
    op_r3(OP_ADD_W, 5'd5, 5'd0, 5'd2);    // No stall, r0 still zero
    run_program("r0");
endtask

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    // Cycle budgets of the alu, forwarding, load/store, branch and r0 tests
    localparam int TOTAL_CYCLES = 40 + 40 + 150 + 60 + 50;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [3:0]        ena;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   value;
    } retire_t;

    logic              cpu_clk = 1'b0;
    logic              cpu_rstn;
    logic              ifetch_rreq;
    logic [XLEN-1:0]   ifetch_addr;
    logic              ifetch_valid;
    logic [XLEN-1:0]   ifetch_inst;
    logic [3:0]        daccess_ren;
    logic [XLEN-1:0]   daccess_addr;
    logic              daccess_valid;
    logic [XLEN-1:0]   daccess_rdata;
    logic [3:0]        daccess_wen;
    logic [XLEN-1:0]   daccess_wdata;
    logic              daccess_wresp;
    logic              debug_wb_valid;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [3:0]        debug_wb_ena;
    logic [REG_AW-1:0] debug_wb_reg;
    logic [XLEN-1:0]   debug_wb_value;

    logic [XLEN-1:0] imem [64];
    int              prog_len;
    logic [XLEN-1:0] iword;        // Word index of the fetch address
    logic [XLEN-1:0] dmem [256];
    logic [15:0]     lfsr = 16'd50;
    logic [1:0]      lat = 2'd0;   // Wait cycles of the current data access
    logic [1:0]      waited;
    logic            dreq;
    logic            dresp;

    retire_t         retired [$];
    retire_t         expected [$];
    int              ret_base;
    logic [XLEN-1:0] gr [32];      // ISA view of the register file
    logic [XLEN-1:0] dref [256];   // ISA view of data memory
    logic [XLEN-1:0] pc_at;        // Address of the next emitted instruction

    cpu_top DUT (.*);

    always #5 cpu_clk = ~cpu_clk;

    // Same-cycle instruction memory, silent past the end of the program
    assign iword        = (ifetch_addr - RESET_PC) >> 2;
    assign ifetch_valid = ifetch_rreq && (iword < XLEN'(prog_len));
    assign ifetch_inst  = ifetch_valid ? imem[iword[5:0]] : '0;

    // Response comes once the wait count reaches the drawn latency
    assign dreq          = (daccess_ren != 4'h0) || (daccess_wen != 4'h0);
    assign dresp         = dreq && (waited == lat);
    assign daccess_valid = dresp && (daccess_ren != 4'h0);
    assign daccess_wresp = dresp && (daccess_wen != 4'h0);
    assign daccess_rdata = dmem[daccess_addr[9:2]];

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    always @(posedge cpu_clk or negedge cpu_rstn) begin : data_mem_model
        logic [15:0] s1;
        logic [15:0] s2;
        if (!cpu_rstn) begin
            waited <= 2'd0;
        end else if (dresp) begin
            if (daccess_wen != 4'h0)
                dmem[daccess_addr[9:2]] <= daccess_wdata;
            s1 = lfsr_step(lfsr);   // One step per latency bit
            s2 = lfsr_step(s1);
            lfsr   <= s2;
            lat    <= {s2[0], s1[0]};
            waited <= 2'd0;
        end else if (dreq) begin
            waited <= waited + 2'd1;
        end
    end

    always @(posedge cpu_clk) begin : retire_monitor
        retire_t r;
        if (cpu_rstn && debug_wb_valid) begin
            r.pc    = debug_wb_pc;
            r.ena   = debug_wb_ena;
            r.rd    = debug_wb_reg;
            r.value = debug_wb_value;
            retired.push_back(r);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_reg(input logic [REG_AW-1:0] got, input logic [REG_AW-1:0] exp,
                             input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0d ns: %s is r%0d, expected r%0d", $time, what, got, exp));
    endtask

    task automatic check_ena(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [XLEN-1:0] r3_result(input logic [16:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_ADD_W: return a + b;
            OP_SUB_W: return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:  return '0;
        endcase
    endfunction

    // Places one instruction and records how it must retire
    task automatic emit(input logic [XLEN-1:0] inst, input logic we,
                        input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] value);
        retire_t r;
        r.pc    = pc_at;
        r.ena   = (we && rd != '0) ? 4'hf : 4'h0;
        r.rd    = rd;
        r.value = value;
        expected.push_back(r);
        if (we && rd != '0)
            gr[rd] = value;
        imem[prog_len[5:0]] = inst;
        prog_len++;
        pc_at += 32'd4;
    endtask

    task automatic op_r3(input logic [16:0] op, input logic [REG_AW-1:0] rd,
                         input logic [REG_AW-1:0] rj, input logic [REG_AW-1:0] rk);
        emit({op, rk, rj, rd}, 1'b1, rd, r3_result(op, gr[rj], gr[rk]));
    endtask

    task automatic op_addi(input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rj,
                           input logic [11:0] imm);
        emit({OP_ADDI_W, imm, rj, rd}, 1'b1, rd, gr[rj] + {{20{imm[11]}}, imm});
    endtask

    task automatic op_lu12i(input logic [REG_AW-1:0] rd, input logic [19:0] imm);
        emit({OP_LU12I_W, imm, rd}, 1'b1, rd, {imm, 12'h000});
    endtask

    task automatic op_st(input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rj,
                         input logic [11:0] imm);
        logic [XLEN-1:0] addr;
        addr = gr[rj] + {{20{imm[11]}}, imm};
        dref[addr[9:2]] = gr[rd];
        emit({OP_ST_W, imm, rj, rd}, 1'b0, rd, '0);
    endtask

    task automatic op_ld(input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rj,
                         input logic [11:0] imm);
        logic [XLEN-1:0] addr;
        addr = gr[rj] + {{20{imm[11]}}, imm};
        emit({OP_LD_W, imm, rj, rd}, 1'b1, rd, dref[addr[9:2]]);
    endtask

    // Target is always two words ahead, so a taken branch skips one slot
    task automatic op_branch(input logic [5:0] op, input logic [REG_AW-1:0] rj,
                             input logic [REG_AW-1:0] rd);
        logic taken;
        taken = (op == OP_BEQ) ? (gr[rj] == gr[rd]) : (gr[rj] != gr[rd]);
        emit({op, 16'd2, rj, rd}, 1'b0, rd, '0);
        if (taken) begin
            imem[prog_len[5:0]] = {OP_ADDI_W, 12'h3ff, 5'd0, 5'd31};   // Squashed slot
            prog_len++;
            pc_at += 32'd4;
        end
    endtask

    task automatic start_program();
        @(posedge cpu_clk);
        cpu_rstn <= 1'b0;
        @(negedge cpu_clk);
        gr       = '{default: '0};
        prog_len = 0;
        pc_at    = RESET_PC;
        expected.delete();
    endtask

    task automatic run_program(input string name);
        retire_t got;
        retire_t exp;
        string   tag;
        ret_base = retired.size();
        repeat (2) @(posedge cpu_clk);
        cpu_rstn <= 1'b1;
        while (retired.size() - ret_base < expected.size())
            @(negedge cpu_clk);
        foreach (expected[i]) begin
            got = retired[ret_base + i];
            exp = expected[i];
            tag = $sformatf("%s retirement %0d", name, i);
            check_word(got.pc, exp.pc, $sformatf("%s pc", tag));
            check_ena(got.ena, exp.ena, $sformatf("%s ena", tag));
            if (exp.ena != 4'h0) begin
                check_reg(got.rd, exp.rd, $sformatf("%s reg", tag));
                check_word(got.value, exp.value, $sformatf("%s value", tag));
            end
        end
        $display("%s: %0d retirements compared", name, expected.size());
    endtask

    `include "tb_tests.svh"

    initial begin
        #(TOTAL_CYCLES * 4 * 10);
        abort_run("Timeout: the tests did not finish within their cycle budget");
    end

    initial begin
        cpu_rstn <= 1'b0;
        test_alu_imm();
        test_forwarding();
        test_load_store();
        test_branches();
        test_r0();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                       cpu_clk,
    input  logic                       cpu_rstn,
    output logic                       ifetch_rreq,
    output logic [cpu_pkg::XLEN-1:0]   ifetch_addr,
    input  logic                       ifetch_valid,
    input  logic [cpu_pkg::XLEN-1:0]   ifetch_inst,
    output logic [3:0]                 daccess_ren,
    output logic [cpu_pkg::XLEN-1:0]   daccess_addr,
    input  logic                       daccess_valid,
    input  logic [cpu_pkg::XLEN-1:0]   daccess_rdata,
    output logic [3:0]                 daccess_wen,
    output logic [cpu_pkg::XLEN-1:0]   daccess_wdata,
    input  logic                       daccess_wresp,
    output logic                       debug_wb_valid,
    output logic [cpu_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [3:0]                 debug_wb_ena,
    output logic [cpu_pkg::REG_AW-1:0] debug_wb_reg,
    output logic [cpu_pkg::XLEN-1:0]   debug_wb_value
);
    import cpu_pkg::*;

    fwd_if fwd ();

    logic                mem_hold;
    logic                load_use;
    logic                redirect;
    logic [XLEN-1:0]     redirect_pc;

    // IF/ID
    logic                id_valid;
    logic [XLEN-1:0]     id_pc;
    inst_u               id_inst;

    // ID/EX
    logic                ex_valid;
    logic [XLEN-1:0]     ex_pc;
    logic [XLEN-1:0]     ex_rd1;
    logic [XLEN-1:0]     ex_rd2;
    logic [XLEN-1:0]     ex_imm;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic                ex_b_imm;
    logic [WD_SEL_W-1:0] ex_wd_sel;
    logic                ex_mem_we;
    logic                ex_rf_we;
    logic [REG_AW-1:0]   ex_wr;

    // EX/MEM
    logic                mem_valid;
    logic [XLEN-1:0]     mem_pc;
    logic [XLEN-1:0]     mem_alu_c;
    logic [XLEN-1:0]     mem_wdata;
    logic [WD_SEL_W-1:0] mem_wd_sel;
    logic                mem_mem_we;
    logic                mem_rf_we;
    logic [REG_AW-1:0]   mem_wr;

    // Register file write from WB
    logic                wb_we;
    logic [REG_AW-1:0]   wb_wr;
    logic [XLEN-1:0]     wb_wd;

    fetch_stage u_fetch (
        .cpu_clk, .cpu_rstn, .mem_hold, .load_use, .redirect, .redirect_pc,
        .ifetch_rreq, .ifetch_addr, .ifetch_valid, .ifetch_inst,
        .id_valid, .id_pc, .id_inst
    );

    decode_stage u_decode (
        .cpu_clk, .cpu_rstn, .mem_hold, .id_valid, .id_pc, .id_inst,
        .fwd        (fwd),
        .wb_we, .wb_wr, .wb_wd, .load_use, .redirect, .redirect_pc,
        .ex_valid, .ex_pc, .ex_rd1, .ex_rd2, .ex_imm, .ex_alu_op, .ex_b_imm,
        .ex_wd_sel, .ex_mem_we, .ex_rf_we, .ex_wr
    );

    execute_stage u_execute (
        .cpu_clk, .cpu_rstn, .mem_hold,
        .ex_valid, .ex_pc, .ex_rd1, .ex_rd2, .ex_imm, .ex_alu_op, .ex_b_imm,
        .ex_wd_sel, .ex_mem_we, .ex_rf_we, .ex_wr,
        .fwd        (fwd),
        .mem_valid, .mem_pc, .mem_alu_c, .mem_wdata, .mem_wd_sel, .mem_mem_we,
        .mem_rf_we, .mem_wr
    );

    memory_stage u_memory (
        .cpu_clk, .cpu_rstn,
        .mem_valid, .mem_pc, .mem_alu_c, .mem_wdata, .mem_wd_sel, .mem_mem_we,
        .mem_rf_we, .mem_wr,
        .daccess_ren, .daccess_addr, .daccess_valid, .daccess_rdata,
        .daccess_wen, .daccess_wdata, .daccess_wresp,
        .mem_hold,
        .fwd        (fwd),
        .wb_we, .wb_wr, .wb_wd,
        .debug_wb_valid, .debug_wb_pc, .debug_wb_ena, .debug_wb_reg, .debug_wb_value
    );

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                         cpu_clk,
    input  logic                         cpu_rstn,
    input  logic                         mem_valid,
    input  logic [cpu_pkg::XLEN-1:0]     mem_pc,
    input  logic [cpu_pkg::XLEN-1:0]     mem_alu_c,
    input  logic [cpu_pkg::XLEN-1:0]     mem_wdata,
    input  logic [cpu_pkg::WD_SEL_W-1:0] mem_wd_sel,
    input  logic                         mem_mem_we,
    input  logic                         mem_rf_we,
    input  logic [cpu_pkg::REG_AW-1:0]   mem_wr,
    output logic [3:0]                   daccess_ren,
    output logic [cpu_pkg::XLEN-1:0]     daccess_addr,
    input  logic                         daccess_valid,
    input  logic [cpu_pkg::XLEN-1:0]     daccess_rdata,
    output logic [3:0]                   daccess_wen,
    output logic [cpu_pkg::XLEN-1:0]     daccess_wdata,
    input  logic                         daccess_wresp,
    output logic                         mem_hold,
    fwd_if.mem_src                       fwd,
    output logic                         wb_we,
    output logic [cpu_pkg::REG_AW-1:0]   wb_wr,
    output logic [cpu_pkg::XLEN-1:0]     wb_wd,
    output logic                         debug_wb_valid,
    output logic [cpu_pkg::XLEN-1:0]     debug_wb_pc,
    output logic [3:0]                   debug_wb_ena,
    output logic [cpu_pkg::REG_AW-1:0]   debug_wb_reg,
    output logic [cpu_pkg::XLEN-1:0]     debug_wb_value
);
    import cpu_pkg::*;

    logic            is_ld;
    logic            is_st;
    logic [XLEN-1:0] sel_wd;
    logic            wb_valid;
    logic [XLEN-1:0] wb_pc;

    assign is_ld = mem_valid & (mem_wd_sel == WD_RAM);
    assign is_st = mem_valid & mem_mem_we;

    // Request stays on the port until its response arrives
    assign daccess_addr  = mem_alu_c;
    assign daccess_ren   = is_ld ? RAM_ALL : 4'h0;
    assign daccess_wen   = is_st ? RAM_ALL : 4'h0;
    assign daccess_wdata = mem_wdata;
    assign mem_hold      = (is_ld & ~daccess_valid) | (is_st & ~daccess_wresp);

    always_comb begin
        case (mem_wd_sel)
            WD_RAM:  sel_wd = daccess_rdata;
            WD_PC4:  sel_wd = mem_pc + 32'd4;
            default: sel_wd = mem_alu_c;
        endcase
    end

    assign fwd.mem_wr = mem_wr;
    assign fwd.mem_we = mem_valid & mem_rf_we;
    assign fwd.mem_wd = sel_wd;

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= mem_valid & ~mem_hold;   // Bubble into WB while waiting
            wb_we    <= mem_valid & ~mem_hold & mem_rf_we;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!mem_hold) begin
            wb_pc <= mem_pc;
            wb_wr <= mem_wr;
            wb_wd <= sel_wd;
        end
    end

    assign debug_wb_valid = wb_valid;
    assign debug_wb_pc    = wb_pc;
    assign debug_wb_ena   = {4{wb_we}};
    assign debug_wb_reg   = wb_wr;
    assign debug_wb_value = wb_wd;

    a_resp_exclusive: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        !(daccess_valid && daccess_wresp));

    // A response only answers an outstanding request
    a_resp_requested: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        (daccess_valid |-> (daccess_ren != 4'h0)) and
        (daccess_wresp |-> (daccess_wen != 4'h0)));

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                         cpu_clk,
    input  logic                         cpu_rstn,
    input  logic                         mem_hold,
    input  logic                         ex_valid,
    input  logic [cpu_pkg::XLEN-1:0]     ex_pc,
    input  logic [cpu_pkg::XLEN-1:0]     ex_rd1,
    input  logic [cpu_pkg::XLEN-1:0]     ex_rd2,
    input  logic [cpu_pkg::XLEN-1:0]     ex_imm,
    input  logic [cpu_pkg::ALU_OP_W-1:0] ex_alu_op,
    input  logic                         ex_b_imm,
    input  logic [cpu_pkg::WD_SEL_W-1:0] ex_wd_sel,
    input  logic                         ex_mem_we,
    input  logic                         ex_rf_we,
    input  logic [cpu_pkg::REG_AW-1:0]   ex_wr,
    fwd_if.ex_src                        fwd,
    output logic                         mem_valid,
    output logic [cpu_pkg::XLEN-1:0]     mem_pc,
    output logic [cpu_pkg::XLEN-1:0]     mem_alu_c,
    output logic [cpu_pkg::XLEN-1:0]     mem_wdata,
    output logic [cpu_pkg::WD_SEL_W-1:0] mem_wd_sel,
    output logic                         mem_mem_we,
    output logic                         mem_rf_we,
    output logic [cpu_pkg::REG_AW-1:0]   mem_wr
);
    import cpu_pkg::*;

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_c;

    assign alu_b = ex_b_imm ? ex_imm : ex_rd2;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_c = ex_rd1 + alu_b;   // Also load/store address
            ALU_SUB: alu_c = ex_rd1 - alu_b;
            ALU_AND: alu_c = ex_rd1 & alu_b;
            ALU_OR:  alu_c = ex_rd1 | alu_b;
            ALU_XOR: alu_c = ex_rd1 ^ alu_b;
            ALU_SLT: alu_c = {{(XLEN-1){1'b0}}, $signed(ex_rd1) < $signed(alu_b)};
            ALU_LUI: alu_c = alu_b;
            default: alu_c = '0;
        endcase
    end

    assign fwd.ex_wr      = ex_wr;
    assign fwd.ex_we      = ex_valid & ex_rf_we;
    assign fwd.ex_wd      = (ex_wd_sel == WD_PC4) ? ex_pc + 32'd4 : alu_c;
    assign fwd.ex_is_load = ex_valid & (ex_wd_sel == WD_RAM);

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            mem_valid  <= 1'b0;
            mem_mem_we <= 1'b0;
            mem_rf_we  <= 1'b0;
        end else if (!mem_hold) begin
            mem_valid  <= ex_valid;
            mem_mem_we <= ex_mem_we;
            mem_rf_we  <= ex_rf_we;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!mem_hold) begin
            mem_pc     <= ex_pc;
            mem_alu_c  <= alu_c;
            mem_wdata  <= ex_rd2;   // Store data
            mem_wd_sel <= ex_wd_sel;
            mem_wr     <= ex_wr;
        end
    end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                     cpu_clk,
    input  logic                     cpu_rstn,
    input  logic                     mem_hold,
    input  logic                     load_use,
    input  logic                     redirect,
    input  logic [cpu_pkg::XLEN-1:0] redirect_pc,
    output logic                     ifetch_rreq,
    output logic [cpu_pkg::XLEN-1:0] ifetch_addr,
    input  logic                     ifetch_valid,
    input  logic [cpu_pkg::XLEN-1:0] ifetch_inst,
    output logic                     id_valid,
    output logic [cpu_pkg::XLEN-1:0] id_pc,
    output cpu_pkg::inst_u           id_inst
);
    import cpu_pkg::*;

    logic            run_q;   // Low until the first edge out of reset
    logic [XLEN-1:0] pc;
    logic            stall;
    logic            take;    // Fetched word goes into IF/ID

    assign stall       = mem_hold | load_use;
    assign ifetch_rreq = run_q & ~stall;
    assign ifetch_addr = pc;
    assign take        = ifetch_rreq & ifetch_valid & ~redirect;

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            run_q    <= 1'b0;
            pc       <= RESET_PC;
            id_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (!stall) begin
                id_valid <= take;   // Squash on redirect, bubble on missed fetch
                if (redirect)
                    pc <= redirect_pc;
                else if (take)
                    pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (take) begin
            id_pc   <= pc;
            id_inst <= ifetch_inst;
        end
    end

    // Branch targets from decode must stay word aligned
    a_fetch_aligned: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        ifetch_rreq |-> (ifetch_addr[1:0] == 2'b00));

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                         cpu_clk,
    input  logic                         cpu_rstn,
    input  logic                         mem_hold,
    input  logic                         id_valid,
    input  logic [cpu_pkg::XLEN-1:0]     id_pc,
    input  cpu_pkg::inst_u               id_inst,
    fwd_if.sink                          fwd,
    input  logic                         wb_we,
    input  logic [cpu_pkg::REG_AW-1:0]   wb_wr,
    input  logic [cpu_pkg::XLEN-1:0]     wb_wd,
    output logic                         load_use,
    output logic                         redirect,
    output logic [cpu_pkg::XLEN-1:0]     redirect_pc,
    output logic                         ex_valid,
    output logic [cpu_pkg::XLEN-1:0]     ex_pc,
    output logic [cpu_pkg::XLEN-1:0]     ex_rd1,
    output logic [cpu_pkg::XLEN-1:0]     ex_rd2,
    output logic [cpu_pkg::XLEN-1:0]     ex_imm,
    output logic [cpu_pkg::ALU_OP_W-1:0] ex_alu_op,
    output logic                         ex_b_imm,
    output logic [cpu_pkg::WD_SEL_W-1:0] ex_wd_sel,
    output logic                         ex_mem_we,
    output logic                         ex_rf_we,
    output logic [cpu_pkg::REG_AW-1:0]   ex_wr
);
    import cpu_pkg::*;

    logic                is_r3, is_addi, is_ld, is_st, is_lu12i, is_beq, is_bne;
    logic [ALU_OP_W-1:0] alu_op;
    logic [REG_AW-1:0]   ra1, ra2;
    logic                use1, use2;
    logic                rf_we;
    logic [XLEN-1:0]     imm, br_off;
    logic [XLEN-1:0]     rf_rd1, rf_rd2;
    logic [XLEN-1:0]     op1, op2;   // Operands after forwarding

    assign is_addi  = (id_inst.ri12.opcode == OP_ADDI_W);
    assign is_ld    = (id_inst.ri12.opcode == OP_LD_W);
    assign is_st    = (id_inst.ri12.opcode == OP_ST_W);
    assign is_lu12i = (id_inst.ri20.opcode == OP_LU12I_W);
    assign is_beq   = (id_inst.br.opcode == OP_BEQ);
    assign is_bne   = (id_inst.br.opcode == OP_BNE);

    always_comb begin
        is_r3  = 1'b1;
        alu_op = ALU_ADD;   // addi, ld and st add too
        case (id_inst.r3.opcode)
            OP_ADD_W: alu_op = ALU_ADD;
            OP_SUB_W: alu_op = ALU_SUB;
            OP_AND:   alu_op = ALU_AND;
            OP_OR:    alu_op = ALU_OR;
            OP_XOR:   alu_op = ALU_XOR;
            OP_SLT:   alu_op = ALU_SLT;
            default:  is_r3  = 1'b0;
        endcase
        if (is_lu12i)
            alu_op = ALU_LUI;
    end

    // Stores and branches read rd as second source
    assign ra1   = id_inst.r3.rj;
    assign ra2   = is_r3 ? id_inst.r3.rk : id_inst.br.rd;
    assign use1  = is_r3 | is_addi | is_ld | is_st | is_beq | is_bne;
    assign use2  = is_r3 | is_st | is_beq | is_bne;
    assign rf_we = (is_r3 | is_addi | is_lu12i | is_ld) & (id_inst.r3.rd != '0);

    assign imm    = is_lu12i ? {id_inst.ri20.imm20, 12'b0}
                             : {{20{id_inst.ri12.imm12[11]}}, id_inst.ri12.imm12};
    assign br_off = {{14{id_inst.br.offs16[15]}}, id_inst.br.offs16, 2'b00};

    reg_file u_rf (
        .cpu_clk (cpu_clk),
        .ra1     (ra1),
        .ra2     (ra2),
        .rd1     (rf_rd1),
        .rd2     (rf_rd2),
        .we      (wb_we),
        .wa      (wb_wr),
        .wd      (wb_wd)
    );

    // Youngest producer wins
    always_comb begin
        if (fwd.ex_we && fwd.ex_wr == ra1)
            op1 = fwd.ex_wd;
        else if (fwd.mem_we && fwd.mem_wr == ra1)
            op1 = fwd.mem_wd;
        else
            op1 = rf_rd1;
    end

    always_comb begin
        if (fwd.ex_we && fwd.ex_wr == ra2)
            op2 = fwd.ex_wd;
        else if (fwd.mem_we && fwd.mem_wr == ra2)
            op2 = fwd.mem_wd;
        else
            op2 = rf_rd2;
    end

    assign load_use = id_valid & fwd.ex_is_load & fwd.ex_we &
                      ((use1 & (ra1 == fwd.ex_wr)) | (use2 & (ra2 == fwd.ex_wr)));

    assign redirect    = id_valid & ~load_use &
                         ((is_beq & (op1 == op2)) | (is_bne & (op1 != op2)));
    assign redirect_pc = id_pc + br_off;

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            ex_valid  <= 1'b0;
            ex_rf_we  <= 1'b0;
            ex_mem_we <= 1'b0;
        end else if (!mem_hold) begin
            ex_valid  <= id_valid & ~load_use;   // Bubble into EX on load-use
            ex_rf_we  <= id_valid & ~load_use & rf_we;
            ex_mem_we <= id_valid & ~load_use & is_st;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!mem_hold) begin
            ex_pc     <= id_pc;
            ex_rd1    <= op1;
            ex_rd2    <= op2;
            ex_imm    <= imm;
            ex_alu_op <= alu_op;
            ex_b_imm  <= ~is_r3;
            ex_wd_sel <= is_ld ? WD_RAM : WD_ALU;
            ex_wr     <= id_inst.r3.rd;
        end
    end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                       cpu_clk,
    input  logic [cpu_pkg::REG_AW-1:0] ra1,
    input  logic [cpu_pkg::REG_AW-1:0] ra2,
    output logic [cpu_pkg::XLEN-1:0]   rd1,
    output logic [cpu_pkg::XLEN-1:0]   rd2,
    input  logic                       we,
    input  logic [cpu_pkg::REG_AW-1:0] wa,
    input  logic [cpu_pkg::XLEN-1:0]   wd
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];   // Entry 0 never written

    always_ff @(posedge cpu_clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // Same-cycle write is visible to decode
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== common/fwd_if.sv ====
`timescale 1ns/1ps

interface fwd_if;
    import cpu_pkg::*;

    logic [REG_AW-1:0] ex_wr;
    logic              ex_we;
    logic [XLEN-1:0]   ex_wd;
    logic              ex_is_load;   // Value not known before MEM

    logic [REG_AW-1:0] mem_wr;
    logic              mem_we;
    logic [XLEN-1:0]   mem_wd;

    modport ex_src (
        output ex_wr, ex_we, ex_wd, ex_is_load
    );

    modport mem_src (
        output mem_wr, mem_we, mem_wd
    );

    modport sink (
        input ex_wr, ex_we, ex_wd, ex_is_load,
        input mem_wr, mem_we, mem_wd
    );

endinterface

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 3'd6;   // Passes operand B through

    localparam int WD_SEL_W = 2;
    localparam logic [WD_SEL_W-1:0] WD_ALU = 2'd0;
    localparam logic [WD_SEL_W-1:0] WD_RAM = 2'd1;
    localparam logic [WD_SEL_W-1:0] WD_PC4 = 2'd2;

    localparam logic [3:0] RAM_ALL = 4'hf;   // Word access byte enable

    // 3R format, opcode in bits [31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits [31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;   // Word offset
            logic [4:0]  rj;
            logic [4:0]  rd;
        } br;
    } inst_u;

endpackage
